// ==== common/fsync_node_pkg.sv ====
package fsync_node_pkg;

  // barrier id and level widths
  localparam int unsigned ID_WIDTH   = 3;
  localparam int unsigned LVL_WIDTH  = 2;

  // child ports per direction (horizontal or vertical pair)
  localparam int unsigned PAIR_PORTS = 2;

  // one arrival entry per id
  localparam int unsigned N_IDS      = 2 ** ID_WIDTH;

  typedef logic [ID_WIDTH-1:0]  fsync_id_t;
  typedef logic [LVL_WIDTH-1:0] fsync_lvl_t;

  // request forwarded to the parent, level already reduced
  typedef struct packed {
    fsync_id_t  id;
    fsync_lvl_t lvl;
  } fsync_req_t;

endpackage

// ==== common/fsync_evt_if.sv ====
`timescale 1ns/1ps

// completion events, one slot per pair port
interface fsync_evt_if
  import fsync_node_pkg::*;
();

  logic       valid [PAIR_PORTS]; // single-cycle strobe
  fsync_id_t  id    [PAIR_PORTS];
  fsync_lvl_t lvl   [PAIR_PORTS]; // level for the parent, minus one
  logic       term  [PAIR_PORTS]; // barrier ends at this node

  modport aggr (
    output valid,
    output id,
    output lvl,
    output term
  );

  modport tx (
    input valid,
    input id,
    input lvl,
    input term
  );

endinterface

// ==== src/fsync_fifo.sv ====
`timescale 1ns/1ps

module fsync_fifo
  import fsync_node_pkg::*;
#(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = N_IDS
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i [PAIR_PORTS],
  input  payload_t data_i [PAIR_PORTS],
  input  logic     pop_i,
  output logic     empty_o,
  output logic     full_o,
  output payload_t data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] wr_ptr_d;
  logic [PTR_W-1:0] wr_idx [PAIR_PORTS];
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;

  // wraps for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // slot 0 takes the first free entry, slot 1 the one after it
  always_comb begin
    wr_ptr_d = wr_ptr_q;
    cnt_d    = cnt_q;
    for (int p = 0; p < PAIR_PORTS; p++) begin
      wr_idx[p] = wr_ptr_d;
      if (push_i[p]) begin
        wr_ptr_d = ptr_inc(wr_ptr_d);
        cnt_d    = cnt_d + 1'b1;
      end
    end
    if (pop_i) cnt_d = cnt_d - 1'b1;
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < PAIR_PORTS; p++) begin
      if (push_i[p]) mem_q[wr_idx[p]] <= data_i[p];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_d;
      cnt_q    <= cnt_d;
      if (pop_i) rd_ptr_q <= ptr_inc(rd_ptr_q);
    end
  end

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign data_o  = mem_q[rd_ptr_q]; // head, valid when not empty

endmodule

// ==== fsync_node/fsync_aggr.sv ====
`timescale 1ns/1ps

module fsync_aggr
  import fsync_node_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_valid_i [PAIR_PORTS],
  input  fsync_id_t  req_id_i    [PAIR_PORTS],
  input  fsync_lvl_t req_lvl_i   [PAIR_PORTS],
  fsync_evt_if.aggr  evt
);

  logic                  req_valid_q [PAIR_PORTS];
  fsync_id_t             req_id_q    [PAIR_PORTS];
  fsync_lvl_t            req_lvl_q   [PAIR_PORTS];

  // arrival bits per id, bit p set once port p has arrived
  logic [PAIR_PORTS-1:0] arr_q [N_IDS];
  logic [PAIR_PORTS-1:0] arr_d [N_IDS];

  logic                  same_id;
  logic                  done [PAIR_PORTS];

  logic                  evt_valid_q [PAIR_PORTS];
  fsync_id_t             evt_id_q    [PAIR_PORTS];
  fsync_lvl_t            evt_lvl_q   [PAIR_PORTS];
  logic                  evt_term_q  [PAIR_PORTS];

  // input sampling
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= '{default: 1'b0};
    end else begin
      req_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    req_id_q  <= req_id_i;
    req_lvl_q <= req_lvl_i;
  end

  // both ports on one id in the same cycle complete together, in slot 0
  assign same_id = req_valid_q[0] && req_valid_q[1] && (req_id_q[0] == req_id_q[1]);
  assign done[0] = req_valid_q[0] && (arr_q[req_id_q[0]][1] || same_id);
  assign done[1] = req_valid_q[1] && arr_q[req_id_q[1]][0] && !same_id;

  // a repeated arrival just sets an already set bit
  always_comb begin
    arr_d = arr_q;
    for (int p = 0; p < PAIR_PORTS; p++) begin
      if (req_valid_q[p]) arr_d[req_id_q[p]][p] = 1'b1;
    end
    // completion frees the entry for reuse
    for (int p = 0; p < PAIR_PORTS; p++) begin
      if (done[p]) arr_d[req_id_q[p]] = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arr_q       <= '{default: '0};
      evt_valid_q <= '{default: 1'b0};
    end else begin
      arr_q       <= arr_d;
      evt_valid_q <= done;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < PAIR_PORTS; p++) begin
      evt_id_q[p]   <= req_id_q[p];
      evt_term_q[p] <= (req_lvl_q[p] == '0); // level 0 ends here
      if (req_lvl_q[p] != '0) begin
        evt_lvl_q[p] <= req_lvl_q[p] - 1'b1;
      end else begin
        evt_lvl_q[p] <= '0;
      end
    end
  end

  for (genvar p = 0; p < PAIR_PORTS; p++) begin : gen_evt
    assign evt.valid[p] = evt_valid_q[p];
    assign evt.id[p]    = evt_id_q[p];
    assign evt.lvl[p]   = evt_lvl_q[p];
    assign evt.term[p]  = evt_term_q[p];
  end

endmodule

// ==== fsync_node/fsync_tx.sv ====
`timescale 1ns/1ps

module fsync_tx
  import fsync_node_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = N_IDS
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  fsync_evt_if.tx    evt,
  input  logic       rsp_out_valid_i,
  input  fsync_id_t  rsp_out_id_i,
  output logic       req_out_valid_o,
  output fsync_req_t req_out_o,
  output logic       rsp_valid_o,
  output fsync_id_t  rsp_id_o
);

  logic       fwd_push  [PAIR_PORTS];
  fsync_req_t fwd_data  [PAIR_PORTS];
  logic       term_push [PAIR_PORTS];
  logic       fwd_empty;
  logic       fwd_pop;
  fsync_req_t fwd_head;
  logic       term_empty;
  logic       term_pop;
  fsync_id_t  term_head;

  logic       req_out_valid_q;
  fsync_req_t req_out_q;
  logic       rsp_valid_q;
  fsync_id_t  rsp_id_q;

  // split events by where the barrier ends
  always_comb begin
    for (int p = 0; p < PAIR_PORTS; p++) begin
      fwd_push[p]  = evt.valid[p] && !evt.term[p];
      term_push[p] = evt.valid[p] && evt.term[p];
      fwd_data[p]  = '{id: evt.id[p], lvl: evt.lvl[p]};
    end
  end

  fsync_fifo #(
    .payload_t ( fsync_req_t ),
    .DEPTH     ( FIFO_DEPTH  )
  ) i_fwd_fifo (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .push_i  ( fwd_push  ),
    .data_i  ( fwd_data  ),
    .pop_i   ( fwd_pop   ),
    .empty_o ( fwd_empty ),
    .full_o  (           ),
    .data_o  ( fwd_head  )
  );

  fsync_fifo #(
    .payload_t ( fsync_id_t ),
    .DEPTH     ( FIFO_DEPTH )
  ) i_term_fifo (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .push_i  ( term_push  ),
    .data_i  ( evt.id     ),
    .pop_i   ( term_pop   ),
    .empty_o ( term_empty ),
    .full_o  (            ),
    .data_o  ( term_head  )
  );

  assign fwd_pop  = !fwd_empty; // one forward per cycle
  assign term_pop = !term_empty && !rsp_out_valid_i; // parent response first

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_out_valid_q <= 1'b0;
      rsp_valid_q     <= 1'b0;
    end else begin
      req_out_valid_q <= fwd_pop;
      rsp_valid_q     <= rsp_out_valid_i || term_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fwd_pop) req_out_q <= fwd_head;
    if (rsp_out_valid_i) begin
      rsp_id_q <= rsp_out_id_i;
    end else if (term_pop) begin
      rsp_id_q <= term_head;
    end
  end

  assign req_out_valid_o = req_out_valid_q;
  assign req_out_o       = req_out_q;
  assign rsp_valid_o     = rsp_valid_q;
  assign rsp_id_o        = rsp_id_q;

endmodule

// ==== fsync_node/fsync_node.sv ====
`timescale 1ns/1ps

module fsync_node
  import fsync_node_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = N_IDS
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  // horizontal pair
  input  logic       h_req_valid_i [PAIR_PORTS],
  input  fsync_id_t  h_req_id_i    [PAIR_PORTS],
  input  fsync_lvl_t h_req_lvl_i   [PAIR_PORTS],
  input  logic       h_rsp_out_valid_i,
  input  fsync_id_t  h_rsp_out_id_i,
  output logic       h_req_out_valid_o,
  output fsync_req_t h_req_out_o,
  output logic       h_rsp_valid_o, // shared by both ports of the pair
  output fsync_id_t  h_rsp_id_o,

  // vertical pair
  input  logic       v_req_valid_i [PAIR_PORTS],
  input  fsync_id_t  v_req_id_i    [PAIR_PORTS],
  input  fsync_lvl_t v_req_lvl_i   [PAIR_PORTS],
  input  logic       v_rsp_out_valid_i,
  input  fsync_id_t  v_rsp_out_id_i,
  output logic       v_req_out_valid_o,
  output fsync_req_t v_req_out_o,
  output logic       v_rsp_valid_o,
  output fsync_id_t  v_rsp_id_o
);

  // each direction has its own table and queues
  fsync_evt_if h_evt ();
  fsync_evt_if v_evt ();

  fsync_aggr i_h_aggr (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .req_valid_i ( h_req_valid_i ),
    .req_id_i    ( h_req_id_i    ),
    .req_lvl_i   ( h_req_lvl_i   ),
    .evt         ( h_evt.aggr    )
  );

  fsync_tx #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_h_tx (
    .clk_i           ( clk_i             ),
    .rst_ni          ( rst_ni            ),
    .evt             ( h_evt.tx          ),
    .rsp_out_valid_i ( h_rsp_out_valid_i ),
    .rsp_out_id_i    ( h_rsp_out_id_i    ),
    .req_out_valid_o ( h_req_out_valid_o ),
    .req_out_o       ( h_req_out_o       ),
    .rsp_valid_o     ( h_rsp_valid_o     ),
    .rsp_id_o        ( h_rsp_id_o        )
  );

  fsync_aggr i_v_aggr (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .req_valid_i ( v_req_valid_i ),
    .req_id_i    ( v_req_id_i    ),
    .req_lvl_i   ( v_req_lvl_i   ),
    .evt         ( v_evt.aggr    )
  );

  fsync_tx #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_v_tx (
    .clk_i           ( clk_i             ),
    .rst_ni          ( rst_ni            ),
    .evt             ( v_evt.tx          ),
    .rsp_out_valid_i ( v_rsp_out_valid_i ),
    .rsp_out_id_i    ( v_rsp_out_id_i    ),
    .req_out_valid_o ( v_req_out_valid_o ),
    .req_out_o       ( v_req_out_o       ),
    .rsp_valid_o     ( v_rsp_valid_o     ),
    .rsp_id_o        ( v_rsp_id_o        )
  );

endmodule

// ==== dv/fsync_fifo_props.sv ====
`timescale 1ns/1ps

module fsync_fifo_props
  import fsync_node_pkg::*;
(
  input logic clk_i,
  input logic rst_ni,
  input logic push_i [PAIR_PORTS],
  input logic pop_i,
  input logic empty_i,
  input logic full_i
);

  // ids are reused only after their output, so a full queue sees no push
  no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(full_i && (push_i[0] || push_i[1]))
  ) else $error("fifo pushed while full");

  no_pop_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(empty_i && pop_i)
  ) else $error("fifo popped while empty");

  full_and_empty_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(full_i && empty_i)
  ) else $error("fifo flags full and empty together");

endmodule

bind fsync_fifo fsync_fifo_props i_fifo_props (
  .clk_i   ( clk_i   ),
  .rst_ni  ( rst_ni  ),
  .push_i  ( push_i  ),
  .pop_i   ( pop_i   ),
  .empty_i ( empty_o ),
  .full_i  ( full_o  )
);

// ==== dv/tb_fsync_node.sv ====
`timescale 1ns/1ps

module tb_fsync_node
  import fsync_node_pkg::*;
();

  localparam int CLK_PERIOD      = 4;
  localparam int N_REQS          = 400;
  localparam int WATCHDOG_CYCLES = 20 * N_REQS + 100;

  logic clk_i;
  logic rst_ni;

  // stimulus per direction, index 0 is h and 1 is v
  logic       req_valid    [2][PAIR_PORTS];
  fsync_id_t  req_id       [2][PAIR_PORTS];
  fsync_lvl_t req_lvl      [2][PAIR_PORTS];
  logic       rsp_in_valid [2];
  fsync_id_t  rsp_in_id    [2];
  logic       req_out_valid [2];
  fsync_req_t req_out       [2];
  logic       rsp_valid     [2];
  fsync_id_t  rsp_id        [2];

  logic       h_req_valid [PAIR_PORTS];
  fsync_id_t  h_req_id    [PAIR_PORTS];
  fsync_lvl_t h_req_lvl   [PAIR_PORTS];
  logic       v_req_valid [PAIR_PORTS];
  fsync_id_t  v_req_id    [PAIR_PORTS];
  fsync_lvl_t v_req_lvl   [PAIR_PORTS];

  // reference model
  logic [1:0] arr_m   [2][N_IDS]; // arrival bits per id
  bit         busy    [2][N_IDS]; // id in use until its output is seen
  bit         open_b  [2][N_IDS]; // started, not yet complete
  fsync_lvl_t lvl_m   [2][N_IDS];
  fsync_req_t fwd_exp [2][$];
  fsync_id_t  term_exp [2][$];
  bit         pend_rsp_valid [2];
  fsync_id_t  pend_rsp_id    [2];

  int checks;
  int mismatches;
  int other_errors;
  int issued;

  for (genvar p = 0; p < PAIR_PORTS; p++) begin : gen_drive
    assign h_req_valid[p] = req_valid[0][p];
    assign h_req_id[p]    = req_id[0][p];
    assign h_req_lvl[p]   = req_lvl[0][p];
    assign v_req_valid[p] = req_valid[1][p];
    assign v_req_id[p]    = req_id[1][p];
    assign v_req_lvl[p]   = req_lvl[1][p];
  end

  fsync_node #(
    .FIFO_DEPTH ( N_IDS )
  ) dut_i (
    .clk_i             ( clk_i            ),
    .rst_ni            ( rst_ni           ),
    .h_req_valid_i     ( h_req_valid      ),
    .h_req_id_i        ( h_req_id         ),
    .h_req_lvl_i       ( h_req_lvl        ),
    .h_rsp_out_valid_i ( rsp_in_valid[0]  ),
    .h_rsp_out_id_i    ( rsp_in_id[0]     ),
    .h_req_out_valid_o ( req_out_valid[0] ),
    .h_req_out_o       ( req_out[0]       ),
    .h_rsp_valid_o     ( rsp_valid[0]     ),
    .h_rsp_id_o        ( rsp_id[0]        ),
    .v_req_valid_i     ( v_req_valid      ),
    .v_req_id_i        ( v_req_id         ),
    .v_req_lvl_i       ( v_req_lvl        ),
    .v_rsp_out_valid_i ( rsp_in_valid[1]  ),
    .v_rsp_out_id_i    ( rsp_in_id[1]     ),
    .v_req_out_valid_o ( req_out_valid[1] ),
    .v_req_out_o       ( req_out[1]       ),
    .v_rsp_valid_o     ( rsp_valid[1]     ),
    .v_rsp_id_o        ( rsp_id[1]        )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic string dir_name(int d);
    return (d == 0) ? "h" : "v";
  endfunction

  task automatic flag_error(string msg);
    $display("Error at %0t: %s", $time, msg);
    other_errors++;
  endtask

  task automatic check_req(string name, fsync_req_t exp, fsync_req_t act);
    checks++;
    if (act !== exp) begin
      $display("Mismatch in %s at %0t: expected id %0d lvl %0d, actual id %0d lvl %0d",
               name, $time, exp.id, exp.lvl, act.id, act.lvl);
      mismatches++;
    end
  endtask

  task automatic check_rsp(string name, fsync_id_t exp, fsync_id_t act);
    checks++;
    if (act !== exp) begin
      $display("Mismatch in %s at %0t: expected id %0d, actual id %0d",
               name, $time, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_outputs(int d);
    fsync_req_t exp_req;
    fsync_id_t  exp_id;
    if (req_out_valid[d]) begin
      if (fwd_exp[d].size() == 0) begin
        flag_error({dir_name(d), " forward raised with no completed barrier"});
      end else begin
        exp_req = fwd_exp[d].pop_front();
        check_req({dir_name(d), " forward"}, exp_req, req_out[d]);
        busy[d][exp_req.id] = 1'b0;
      end
    end
    if (pend_rsp_valid[d]) begin // parent response from the cycle before
      if (!rsp_valid[d]) flag_error({dir_name(d), " parent response did not appear"});
      else check_rsp({dir_name(d), " parent response"}, pend_rsp_id[d], rsp_id[d]);
    end else if (rsp_valid[d]) begin
      if (term_exp[d].size() == 0) begin
        flag_error({dir_name(d), " response raised with no terminated barrier"});
      end else begin
        exp_id = term_exp[d].pop_front();
        check_rsp({dir_name(d), " termination"}, exp_id, rsp_id[d]);
        busy[d][exp_id] = 1'b0;
      end
    end
  endtask

  task automatic complete_barrier(int d, fsync_id_t id);
    fsync_req_t fwd;
    arr_m[d][id]  = 2'b00;
    open_b[d][id] = 1'b0;
    if (lvl_m[d][id] == '0) begin
      term_exp[d].push_back(id);
    end else begin
      fwd.id  = id;
      fwd.lvl = lvl_m[d][id] - 1'b1;
      fwd_exp[d].push_back(fwd);
    end
  endtask

  // new barriers only while allow_new, otherwise just close the open ones
  task automatic drive_dir(int d, bit allow_new);
    fsync_id_t id;
    for (int p = 0; p < PAIR_PORTS; p++) begin
      req_valid[d][p] = 1'b0;
      if (allow_new) begin
        if ($urandom_range(99) < 40) begin
          id = fsync_id_t'($urandom_range(N_IDS - 1));
          if (!busy[d][id]) begin
            busy[d][id]   = 1'b1;
            open_b[d][id] = 1'b1;
            lvl_m[d][id]  = fsync_lvl_t'($urandom_range(3));
          end
          if (open_b[d][id]) begin // may repeat an earlier arrival
            req_valid[d][p] = 1'b1;
            req_id[d][p]    = id;
            req_lvl[d][p]   = lvl_m[d][id];
          end
        end
      end else begin
        for (int i = 0; i < N_IDS; i++) begin
          if (!req_valid[d][p] && open_b[d][i] && !arr_m[d][i][p]) begin
            req_valid[d][p] = 1'b1;
            req_id[d][p]    = fsync_id_t'(i);
            req_lvl[d][p]   = lvl_m[d][i];
          end
        end
      end
      if (req_valid[d][p]) issued++;
    end
    for (int p = 0; p < PAIR_PORTS; p++) begin
      if (req_valid[d][p]) arr_m[d][req_id[d][p]][p] = 1'b1;
    end
    // slot 0 completes first, a shared id completes only once
    for (int p = 0; p < PAIR_PORTS; p++) begin
      if (req_valid[d][p] && arr_m[d][req_id[d][p]] == 2'b11) begin
        complete_barrier(d, req_id[d][p]);
      end
    end
    rsp_in_valid[d]   = allow_new && ($urandom_range(99) < 15);
    rsp_in_id[d]      = fsync_id_t'($urandom_range(N_IDS - 1));
    pend_rsp_valid[d] = rsp_in_valid[d];
    pend_rsp_id[d]    = rsp_in_id[d];
  endtask

  function automatic bit all_drained();
    for (int d = 0; d < 2; d++) begin
      if (fwd_exp[d].size() != 0 || term_exp[d].size() != 0 || pend_rsp_valid[d]) return 1'b0;
      for (int i = 0; i < N_IDS; i++) begin
        if (open_b[d][i]) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic print_summary();
    $display("Summary: %0d requests, %0d checks, %0d mismatches, %0d other errors",
             issued, checks, mismatches, other_errors);
  endtask

  task automatic run_cycle(bit allow_new);
    @(negedge clk_i);
    for (int d = 0; d < 2; d++) check_outputs(d);
    for (int d = 0; d < 2; d++) drive_dir(d, allow_new);
  endtask

  initial begin
    void'($urandom(32'h9bed));
    rst_ni = 1'b0;
    for (int d = 0; d < 2; d++) begin
      rsp_in_valid[d]   = 1'b0;
      rsp_in_id[d]      = '0;
      pend_rsp_valid[d] = 1'b0;
      pend_rsp_id[d]    = '0;
      for (int p = 0; p < PAIR_PORTS; p++) begin
        req_valid[d][p] = 1'b0;
        req_id[d][p]    = '0;
        req_lvl[d][p]   = '0;
      end
      for (int i = 0; i < N_IDS; i++) begin
        arr_m[d][i]  = 2'b00;
        busy[d][i]   = 1'b0;
        open_b[d][i] = 1'b0;
        lvl_m[d][i]  = '0;
      end
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    while (issued < N_REQS) run_cycle(1'b1);
    while (!all_drained()) run_cycle(1'b0);
    repeat (10) run_cycle(1'b0); // idle tail, nothing may show up
    print_summary();
    if (mismatches == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    flag_error("watchdog expired before all expected outputs were seen");
    print_summary();
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== fsync_node.f ====
common/fsync_node_pkg.sv
common/fsync_evt_if.sv
src/fsync_fifo.sv
fsync_node/fsync_aggr.sv
fsync_node/fsync_tx.sv
fsync_node/fsync_node.sv
dv/fsync_fifo_props.sv
dv/tb_fsync_node.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fsync_node
FILELIST  ?= fsync_node.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= Finished with errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
